// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_tcdm_subsys
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
tcdm_pkg.sv
tcdm_rr_arbiter.sv
tcdm_xbar.sv
tcdm_interconnect_wrap.sv
tcdm_sram_bank.sv
tcdm_subsys_top.sv
tb_tcdm_subsys.sv

// ==== tb_tcdm_subsys.sv ====
module tb_tcdm_subsys;

    localparam int NUM_REQ      = int'(tcdm_pkg::NUM_IN);
    localparam int NUM_BANKS    = int'(tcdm_pkg::NUM_OUT);
    localparam int BANK_DEPTH   = int'(tcdm_pkg::BANK_DEPTH);
    localparam int NUM_WORDS    = NUM_BANKS * BANK_DEPTH;
    localparam int RESET_CYCLES = 10;
    localparam int STRB_OPS     = 30;
    localparam int RAND_OPS     = 150;
    // Cycle budget summed over the tests.
    // An access takes between 2 and 5 cycles.
    localparam int TIMEOUT_CYCLES = (RESET_CYCLES + 10) + (2 * NUM_WORDS * 3)
        + (2 * STRB_OPS * 3) + (4 * 8) + (2 * 12) + (RAND_OPS * 8) + 200;

    logic clk = 1'b0;
    logic reset;
    tcdm_pkg::mem_req_t mem_req [tcdm_pkg::NUM_IN];
    tcdm_pkg::mem_rsp_t mem_rsp [tcdm_pkg::NUM_IN];

    // Expected memory contents, indexed by word address.
    tcdm_pkg::data_t model [NUM_WORDS];
    // Word and grant cycle per requestor for the parallel tests.
    int word_sel [NUM_REQ];
    int acc_cyc  [NUM_REQ];
    // Last requestor granted on each bank predicts the next round-robin start.
    int last_winner [NUM_BANKS];
    int errors    = 0;
    int tests_run = 0;
    int cycle_cnt = 0;

    tcdm_subsys_top u_tcdm_subsys_top (
        .clk_i     (clk),
        .reset_i   (reset),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Byte lanes with strobe set take the new data.
    function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old_word,
                                                    input tcdm_pkg::data_t new_word,
                                                    input tcdm_pkg::strb_t strb);
        tcdm_pkg::data_t res;
        res = old_word;
        for (int k = 0; k < int'(tcdm_pkg::BE_WIDTH); k++) begin
            if (strb[k]) begin
                res[8*k +: 8] = new_word[8*k +: 8];
            end
        end
        return res;
    endfunction

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // No responses and no grants while nobody requests.
    task automatic check_idle();
        for (int r = 0; r < NUM_REQ; r++) begin
            assert (!mem_rsp[r].p.valid) else begin
                $display("** Error: mem_rsp[%0d].p.valid = %h, expected 0", r, mem_rsp[r].p.valid);
                errors++;
            end
            assert (!mem_rsp[r].q_ready) else begin
                $display("** Error: mem_rsp[%0d].q_ready = %h, expected 0", r, mem_rsp[r].q_ready);
                errors++;
            end
        end
    endtask

    // One access on requestor r. Drives on the falling edge, samples one unit later.
    task automatic access_mem(input int r, input logic wr, input int word,
                              input tcdm_pkg::data_t wdata, input tcdm_pkg::strb_t strb,
                              output int acc_cycle);
        tcdm_pkg::mem_req_t req;
        tcdm_pkg::data_t    exp;
        logic               ready;
        int                 held;
        req         = '0;
        req.q_valid = 1'b1;
        req.q.addr  = tcdm_pkg::addr_t'(word * int'(tcdm_pkg::BE_WIDTH));
        req.q.write = wr;
        req.q.data  = wdata;
        req.q.strb  = strb;
        ready       = 1'b0;
        held        = 0;
        @(negedge clk);
        mem_req[r] = req;
        // Hold the request until the bank grants it.
        while (!ready) begin
            #1;
            held++;
            assert (!mem_rsp[r].p.valid) else begin
                $display("Failure: requestor %0d got a response with nothing in flight", r);
                errors++;
            end
            ready = mem_rsp[r].q_ready;
            if (!ready) begin
                @(negedge clk);
            end
        end
        // Accepted at the coming rising edge, so the model moves in grant order.
        acc_cycle = cycle_cnt;
        last_winner[word % NUM_BANKS] = r;
        exp       = model[word];
        if (wr) begin
            model[word] = merge_bytes(model[word], wdata, strb);
        end
        assert (held <= NUM_REQ) else begin
            $display("Failure: requestor %0d waited %0d cycles for a grant", r, held);
            errors++;
        end
        @(negedge clk);
        mem_req[r] = '0;
        #1;
        assert (mem_rsp[r].p.valid) else begin
            $display("Failure: requestor %0d saw no response one cycle after its grant", r);
            errors++;
        end
        if (!wr) begin
            assert (mem_rsp[r].p.data === exp) else begin
                $display("** Error: mem_rsp[%0d].p.data = %h, expected %h (word %h)",
                         r, mem_rsp[r].p.data, exp, word);
                errors++;
            end
        end
    endtask

    // All requestors start in the same cycle on their word_sel entries.
    task automatic run_all_requestors(input logic wr);
        for (int r = 0; r < NUM_REQ; r++) begin
            automatic int rr = r;
            fork
                access_mem(rr, wr, word_sel[rr], $urandom, '1, acc_cyc[rr]);
            join_none
        end
        wait fork;
    endtask

    task automatic check_reset_state();
        int errs;
        errs = errors;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            #1;
            check_idle();
        end
        @(negedge clk);
        reset = 1'b0;
        repeat (4) begin
            #1;
            check_idle();
            @(negedge clk);
        end
        end_test("reset_state", errs);
    endtask

    task automatic write_then_read();
        int errs;
        int cyc;
        errs = errors;
        for (int w = 0; w < NUM_WORDS; w++) begin
            access_mem(0, 1'b1, w, $urandom, '1, cyc);
        end
        for (int w = 0; w < NUM_WORDS; w++) begin
            access_mem(0, 1'b0, w, '0, '0, cyc);
        end
        end_test("write_then_read", errs);
    endtask

    task automatic byte_strobes();
        int errs;
        int cyc;
        int word;
        errs = errors;
        // Walks through every nonzero strobe pattern.
        for (int i = 0; i < STRB_OPS; i++) begin
            word = int'($urandom_range(0, NUM_WORDS - 1));
            access_mem(1, 1'b1, word, $urandom, tcdm_pkg::strb_t'(1 + i % 15), cyc);
            access_mem(2, 1'b0, word, '0, '0, cyc);
        end
        end_test("byte_strobes", errs);
    endtask

    task automatic parallel_banks();
        int errs;
        errs = errors;
        // Even rounds write, odd rounds read the same words back.
        for (int round = 0; round < 4; round++) begin
            if (round % 2 == 0) begin
                for (int r = 0; r < NUM_REQ; r++) begin
                    word_sel[r] = NUM_BANKS * int'($urandom_range(0, BANK_DEPTH - 1))
                                  + (r + round / 2) % NUM_BANKS;
                end
            end
            run_all_requestors(round % 2 == 0);
            for (int r = 0; r < NUM_REQ; r++) begin
                assert (acc_cyc[r] == acc_cyc[0]) else begin
                    $display("** Error: grant cycle of requestor %0d = %h, expected %h",
                             r, acc_cyc[r], acc_cyc[0]);
                    errors++;
                end
            end
        end
        end_test("parallel_banks", errs);
    endtask

    task automatic bank_conflict();
        int errs;
        int first;
        int exp_first;
        int idx;
        errs = errors;
        for (int bank = 0; bank < NUM_BANKS; bank += NUM_BANKS - 1) begin
            // Distinct rows in one bank.
            for (int r = 0; r < NUM_REQ; r++) begin
                word_sel[r] = NUM_BANKS * ((5 * r + bank) % BANK_DEPTH) + bank;
            end
            // Search starts one past the previous winner on this bank.
            exp_first = (last_winner[bank] + 1) % NUM_REQ;
            run_all_requestors(1'b0);
            first = 0;
            for (int r = 1; r < NUM_REQ; r++) begin
                if (acc_cyc[r] < acc_cyc[first]) begin
                    first = r;
                end
            end
            assert (first == exp_first) else begin
                $display("** Error: first winner on bank %0d = %h, expected %h",
                         bank, first, exp_first);
                errors++;
            end
            // One grant per cycle, in cyclic requestor order.
            for (int k = 1; k < NUM_REQ; k++) begin
                idx = (first + k) % NUM_REQ;
                assert (acc_cyc[idx] == acc_cyc[first] + k) else begin
                    $display("** Error: grant cycle of requestor %0d = %h, expected %h",
                             idx, acc_cyc[idx], acc_cyc[first] + k);
                    errors++;
                end
            end
        end
        end_test("bank_conflict", errs);
    endtask

    task automatic random_requestor(input int r);
        int   idle;
        int   word;
        int   cyc;
        logic wr;
        for (int n = 0; n < RAND_OPS; n++) begin
            idle = int'($urandom_range(0, 2));
            repeat (idle) @(negedge clk);
            word = int'($urandom_range(0, NUM_WORDS - 1));
            wr   = 1'($urandom_range(0, 1));
            access_mem(r, wr, word, $urandom, tcdm_pkg::strb_t'($urandom), cyc);
        end
    endtask

    task automatic random_traffic();
        int errs;
        errs = errors;
        for (int r = 0; r < NUM_REQ; r++) begin
            automatic int rr = r;
            fork
                random_requestor(rr);
            join_none
        end
        wait fork;
        end_test("random_traffic", errs);
    endtask

    initial begin
        void'($urandom(32'h2564_7671));
        reset = 1'b1;
        for (int r = 0; r < NUM_REQ; r++) begin
            mem_req[r] = '0;
        end
        // Arbiter pointers start at zero after reset.
        for (int b = 0; b < NUM_BANKS; b++) begin
            last_winner[b] = NUM_REQ - 1;
        end
        check_reset_state();
        write_then_read();
        byte_strobes();
        parallel_banks();
        bank_conflict();
        random_traffic();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the sum of the test budgets.
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== tcdm_interconnect_wrap.sv ====
module tcdm_interconnect_wrap (
    input  logic                clk_i,
    input  logic                reset_i,

    // From the requestors.
    input  tcdm_pkg::mem_req_t  mem_req_i [tcdm_pkg::NUM_IN],
    output tcdm_pkg::mem_rsp_t  mem_rsp_o [tcdm_pkg::NUM_IN],

    // To the banks.
    output tcdm_pkg::mem_req_t  mem_req_o [tcdm_pkg::NUM_OUT],
    input  tcdm_pkg::bank_rsp_t mem_rsp_i [tcdm_pkg::NUM_OUT]
);

    // Flat requestor side bundle.
    tcdm_pkg::in_vec_t                              in_req;
    tcdm_pkg::tcdm_addr_t [tcdm_pkg::NUM_IN-1:0]    in_add;
    tcdm_pkg::in_vec_t                              in_wen;
    tcdm_pkg::data_t      [tcdm_pkg::NUM_IN-1:0]    in_wdata;
    tcdm_pkg::strb_t      [tcdm_pkg::NUM_IN-1:0]    in_be;
    tcdm_pkg::in_vec_t                              in_gnt;
    tcdm_pkg::in_vec_t                              in_vld;
    tcdm_pkg::data_t      [tcdm_pkg::NUM_IN-1:0]    in_rdata;

    // Flat bank side bundle.
    logic                 [tcdm_pkg::NUM_OUT-1:0]   out_req;
    tcdm_pkg::bank_addr_t [tcdm_pkg::NUM_OUT-1:0]   out_add;
    logic                 [tcdm_pkg::NUM_OUT-1:0]   out_wen;
    tcdm_pkg::data_t      [tcdm_pkg::NUM_OUT-1:0]   out_wdata;
    tcdm_pkg::strb_t      [tcdm_pkg::NUM_OUT-1:0]   out_be;
    tcdm_pkg::data_t      [tcdm_pkg::NUM_OUT-1:0]   out_rdata;

    for (genvar i = 0; i < tcdm_pkg::NUM_IN; i++) begin : g_in
        // Upper address bits play no part in routing.
        assign in_req[i]   = mem_req_i[i].q_valid;
        assign in_add[i]   = mem_req_i[i].q.addr[tcdm_pkg::ADDR_WIDTH-1:0];
        assign in_wen[i]   = mem_req_i[i].q.write;
        assign in_wdata[i] = mem_req_i[i].q.data;
        assign in_be[i]    = mem_req_i[i].q.strb;

        assign mem_rsp_o[i].q_ready = in_gnt[i];
        assign mem_rsp_o[i].p.valid = in_vld[i];
        assign mem_rsp_o[i].p.data  = in_rdata[i];
    end

    for (genvar b = 0; b < tcdm_pkg::NUM_OUT; b++) begin : g_out
        assign mem_req_o[b].q_valid = out_req[b];
        // Row zero-extended to the full byte address width.
        assign mem_req_o[b].q.addr  =
            {{(tcdm_pkg::FULL_ADDR_WIDTH - tcdm_pkg::ADDR_MEM_WIDTH){1'b0}}, out_add[b]};
        assign mem_req_o[b].q.write = out_wen[b];
        assign mem_req_o[b].q.data  = out_wdata[b];
        assign mem_req_o[b].q.strb  = out_be[b];

        assign out_rdata[b] = mem_rsp_i[b].p.data;
    end

    tcdm_xbar u_xbar (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (in_req),
        .add_i   (in_add),
        .wen_i   (in_wen),
        .wdata_i (in_wdata),
        .be_i    (in_be),
        .gnt_o   (in_gnt),
        .vld_o   (in_vld),
        .rdata_o (in_rdata),
        .req_o   (out_req),
        .add_o   (out_add),
        .wen_o   (out_wen),
        .wdata_o (out_wdata),
        .be_o    (out_be),
        .rdata_i (out_rdata)
    );

endmodule

// ==== tcdm_pkg.sv ====
package tcdm_pkg;

    // Requestor and bank counts.
    localparam int unsigned NUM_IN  = 4;
    localparam int unsigned NUM_OUT = 4;

    // Data path widths.
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // Address widths.
    // Requestor and bank structs carry a full byte address.
    localparam int unsigned FULL_ADDR_WIDTH = 32;
    // Only the low bits are routed.
    localparam int unsigned ADDR_WIDTH      = 8;
    // Bits below the bank select address bytes inside a word.
    localparam int unsigned BYTE_OFFSET     = $clog2(BE_WIDTH);
    // Bank select sits at byte address bits 3 to 2.
    localparam int unsigned BANK_SEL_WIDTH  = $clog2(NUM_OUT);
    // Bank row sits at byte address bits 7 to 4.
    localparam int unsigned ADDR_MEM_WIDTH  = ADDR_WIDTH - BANK_SEL_WIDTH - BYTE_OFFSET;
    localparam int unsigned BANK_DEPTH      = 2 ** ADDR_MEM_WIDTH;

    // Request accept to response valid, in cycles.
    localparam int unsigned RESP_LAT = 1;

    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [BE_WIDTH-1:0]        strb_t;
    typedef logic [FULL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [ADDR_WIDTH-1:0]      tcdm_addr_t;
    typedef logic [ADDR_MEM_WIDTH-1:0]  bank_addr_t;
    typedef logic [BANK_SEL_WIDTH-1:0]  bank_sel_t;
    typedef logic [$clog2(NUM_IN)-1:0]  in_sel_t;
    typedef logic [NUM_IN-1:0]          in_vec_t;

    // Request phase payload.
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t data;
        strb_t strb;
    } mem_req_chan_t;

    typedef struct packed {
        logic          q_valid;
        mem_req_chan_t q;
    } mem_req_t;

    // Response phase payload.
    typedef struct packed {
        logic  valid;
        data_t data;
    } mem_rsp_chan_t;

    typedef struct packed {
        logic          q_ready;
        mem_rsp_chan_t p;
    } mem_rsp_t;

    // Banks always accept, so only the response phase returns.
    typedef struct packed {
        mem_rsp_chan_t p;
    } bank_rsp_t;

endpackage

// ==== tcdm_rr_arbiter.sv ====
module tcdm_rr_arbiter (
    input  logic              clk_i,
    input  logic              reset_i,
    input  tcdm_pkg::in_vec_t req_i,
    output tcdm_pkg::in_vec_t gnt_o,
    output tcdm_pkg::in_sel_t idx_o
);

    // Priority pointer naming the requestor searched first.
    tcdm_pkg::in_sel_t ptr_q;
    // Candidate index during the cyclic search.
    tcdm_pkg::in_sel_t cand;
    // Set once a requesting input has been found.
    logic              found;
    // Pointer value after a grant.
    tcdm_pkg::in_sel_t ptr_next;

    // Cyclic search starting at the pointer.
    // The first requester wins, later ones are ignored.
    always_comb begin
        found = 1'b0;
        idx_o = '0;
        cand  = '0;
        for (int off = 0; off < int'(tcdm_pkg::NUM_IN); off++) begin
            cand = tcdm_pkg::in_sel_t'((int'(ptr_q) + off) % int'(tcdm_pkg::NUM_IN));
            if (!found && req_i[cand]) begin
                found = 1'b1;
                idx_o = cand;
            end
        end
    end

    // One-hot grant, zero when nobody requests.
    always_comb begin
        gnt_o        = '0;
        gnt_o[idx_o] = found;
    end

    // Winner moves to lowest priority next cycle.
    assign ptr_next =
        tcdm_pkg::in_sel_t'((int'(idx_o) + 1) % int'(tcdm_pkg::NUM_IN));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (found) begin
            ptr_q <= ptr_next;
        end
    end

endmodule

// ==== tcdm_sram_bank.sv ====
module tcdm_sram_bank (
    input  logic                clk_i,
    input  logic                reset_i,
    input  tcdm_pkg::mem_req_t  mem_req_i,
    output tcdm_pkg::bank_rsp_t mem_rsp_o
);

    // Storage array.
    tcdm_pkg::data_t    mem_q [tcdm_pkg::BANK_DEPTH];
    // Word selected by the current request.
    tcdm_pkg::bank_addr_t row;
    // Read data and response valid, one cycle after the request.
    tcdm_pkg::data_t    rdata_q;
    logic               vld_q;

    // The wrapper zero-extends the row, so only the low bits matter.
    assign row = mem_req_i.q.addr[tcdm_pkg::ADDR_MEM_WIDTH-1:0];

    // Byte-strobed write.
    // Read returns the word as it was before this cycle's write.
    always_ff @(posedge clk_i) begin
        if (mem_req_i.q_valid) begin
            if (mem_req_i.q.write) begin
                for (int k = 0; k < int'(tcdm_pkg::BE_WIDTH); k++) begin
                    if (mem_req_i.q.strb[k]) begin
                        mem_q[row][8*k +: 8] <= mem_req_i.q.data[8*k +: 8];
                    end
                end
            end
            rdata_q <= mem_q[row];
        end
    end

    // Response pulse follows every accepted request.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= mem_req_i.q_valid;
        end
    end

    assign mem_rsp_o.p.valid = vld_q;
    assign mem_rsp_o.p.data  = rdata_q;

endmodule

// ==== tcdm_subsys_top.sv ====
module tcdm_subsys_top (
    input  logic               clk_i,
    input  logic               reset_i,
    input  tcdm_pkg::mem_req_t mem_req_i [tcdm_pkg::NUM_IN],
    output tcdm_pkg::mem_rsp_t mem_rsp_o [tcdm_pkg::NUM_IN]
);

    // Links between the interconnect and the banks.
    tcdm_pkg::mem_req_t  bank_req [tcdm_pkg::NUM_OUT];
    tcdm_pkg::bank_rsp_t bank_rsp [tcdm_pkg::NUM_OUT];

    tcdm_interconnect_wrap u_interconnect (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .mem_req_i (mem_req_i),
        .mem_rsp_o (mem_rsp_o),
        .mem_req_o (bank_req),
        .mem_rsp_i (bank_rsp)
    );

    // One single-ported bank per crossbar output.
    for (genvar b = 0; b < tcdm_pkg::NUM_OUT; b++) begin : g_bank
        tcdm_sram_bank u_bank (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .mem_req_i (bank_req[b]),
            .mem_rsp_o (bank_rsp[b])
        );
    end

endmodule

// ==== tcdm_xbar.sv ====
module tcdm_xbar (
    input  logic                                              clk_i,
    input  logic                                              reset_i,

    // Requestor side.
    input  tcdm_pkg::in_vec_t                                 req_i,
    input  tcdm_pkg::tcdm_addr_t [tcdm_pkg::NUM_IN-1:0]       add_i,
    input  tcdm_pkg::in_vec_t                                 wen_i,
    input  tcdm_pkg::data_t      [tcdm_pkg::NUM_IN-1:0]       wdata_i,
    input  tcdm_pkg::strb_t      [tcdm_pkg::NUM_IN-1:0]       be_i,
    output tcdm_pkg::in_vec_t                                 gnt_o,
    output tcdm_pkg::in_vec_t                                 vld_o,
    output tcdm_pkg::data_t      [tcdm_pkg::NUM_IN-1:0]       rdata_o,

    // Bank side.
    output logic                 [tcdm_pkg::NUM_OUT-1:0]      req_o,
    output tcdm_pkg::bank_addr_t [tcdm_pkg::NUM_OUT-1:0]      add_o,
    output logic                 [tcdm_pkg::NUM_OUT-1:0]      wen_o,
    output tcdm_pkg::data_t      [tcdm_pkg::NUM_OUT-1:0]      wdata_o,
    output tcdm_pkg::strb_t      [tcdm_pkg::NUM_OUT-1:0]      be_o,
    input  tcdm_pkg::data_t      [tcdm_pkg::NUM_OUT-1:0]      rdata_i
);

    // Per-bank record of an access in flight.
    typedef struct packed {
        logic              valid;
        tcdm_pkg::in_sel_t idx;
    } trk_t;

    // Bank index and row decoded from each requestor address.
    tcdm_pkg::bank_sel_t  [tcdm_pkg::NUM_IN-1:0]  bank_sel;
    tcdm_pkg::bank_addr_t [tcdm_pkg::NUM_IN-1:0]  bank_row;

    // Requests seen by each bank, grants and winners per bank.
    tcdm_pkg::in_vec_t    [tcdm_pkg::NUM_OUT-1:0] bank_req;
    tcdm_pkg::in_vec_t    [tcdm_pkg::NUM_OUT-1:0] bank_gnt;
    tcdm_pkg::in_sel_t    [tcdm_pkg::NUM_OUT-1:0] bank_idx;

    // Single tracking stage, lines up with the bank read data.
    trk_t [tcdm_pkg::NUM_OUT-1:0] trk_q;

    // Word-interleaved decode.
    // Low bits address bytes, then bank, then row.
    for (genvar i = 0; i < tcdm_pkg::NUM_IN; i++) begin : g_decode
        assign bank_sel[i] = add_i[i][tcdm_pkg::BYTE_OFFSET +: tcdm_pkg::BANK_SEL_WIDTH];
        assign bank_row[i] =
            add_i[i][tcdm_pkg::BYTE_OFFSET + tcdm_pkg::BANK_SEL_WIDTH +: tcdm_pkg::ADDR_MEM_WIDTH];
    end

    // Spread each valid onto the bank it targets.
    always_comb begin
        bank_req = '0;
        for (int i = 0; i < int'(tcdm_pkg::NUM_IN); i++) begin
            bank_req[bank_sel[i]][i] = req_i[i];
        end
    end

    for (genvar b = 0; b < tcdm_pkg::NUM_OUT; b++) begin : g_bank
        tcdm_rr_arbiter u_arb (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .req_i   (bank_req[b]),
            .gnt_o   (bank_gnt[b]),
            .idx_o   (bank_idx[b])
        );

        // Winner payload goes to the bank.
        assign req_o[b]   = |bank_req[b];
        assign add_o[b]   = bank_row[bank_idx[b]];
        assign wen_o[b]   = wen_i[bank_idx[b]];
        assign wdata_o[b] = wdata_i[bank_idx[b]];
        assign be_o[b]    = be_i[bank_idx[b]];
    end

    // A requestor targets one bank, so at most one grant bit is set.
    always_comb begin
        gnt_o = '0;
        for (int b = 0; b < int'(tcdm_pkg::NUM_OUT); b++) begin
            gnt_o = gnt_o | bank_gnt[b];
        end
    end

    // Record who won each bank this cycle.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trk_q <= '0;
        end else begin
            for (int b = 0; b < int'(tcdm_pkg::NUM_OUT); b++) begin
                trk_q[b].valid <= req_o[b];
                trk_q[b].idx   <= bank_idx[b];
            end
        end
    end

    // Route read data back to the recorded winner.
    // Each requestor has at most one access per bank cycle, so no clash.
    always_comb begin
        vld_o   = '0;
        rdata_o = '0;
        for (int b = 0; b < int'(tcdm_pkg::NUM_OUT); b++) begin
            if (trk_q[b].valid) begin
                vld_o[trk_q[b].idx]   = 1'b1;
                rdata_o[trk_q[b].idx] = rdata_i[b];
            end
        end
    end

endmodule
